// File: ex_stage.f
verilog/ex_pkg.sv
verilog/ex_issue_reg.sv
verilog/ex_alu.sv
verilog/ex_commit.sv
verilog/ex_stage.sv
sim/ex_clk_gen.sv
sim/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f ex_stage.f \
    --top-module ex_stage_tb -o ex_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
STATUS=$?
cat "$LOG"
if [ $STATUS -ne 0 ]; then
    echo "simulation exited with status $STATUS"
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "result: failed"
    exit 1
fi
if [ $STATUS -ne 0 ]; then
    exit 1
fi
echo "result: passed"
exit 0

// File: sim/ex_clk_gen.sv
`timescale 1ns/1ps

module ex_clk_gen (
    output logic clk_o,
    output logic resetb_o
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // release reset a little after an edge
    initial begin
        resetb_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 resetb_o = 1'b1;
    end

endmodule

// File: sim/ex_patterns.txt
# inputs: v sof sz fi jp cd zn lk pc op opl opr rs1 cmr rs2 rd f3 full empty
# expect: stall jmp jaddr wbwr wbad wbdat lq sq lf3 lrd lrs2 laddr cncl (prev line's instr)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 100 0 5 3 0 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 104 1 5 7 0 0 0 2 0 0 1 0 0 0 1 1 8 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 108 2 f0f0 ff00 0 0 0 3 0 0 1 0 0 0 1 2 fffffffe 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 10c 3 f0f0 0f00 0 0 0 4 0 0 1 0 0 0 1 3 f000 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 110 4 ff 0f 0 0 0 5 0 0 1 0 0 0 1 4 fff0 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 114 5 1 24 0 0 0 6 0 0 1 0 0 0 1 5 f0 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 118 6 80000000 1f 0 0 0 7 0 0 1 0 0 0 1 6 10 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 11c 7 80000000 4 0 0 0 8 0 0 1 0 0 0 1 7 1 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 120 8 ffffffff 1 0 0 0 9 0 0 1 0 0 0 1 8 f8000000 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 124 9 ffffffff 1 0 0 0 a 0 0 1 0 0 0 1 9 1 0 0 0 0 0 0 0
1 0 1 0 0 0 1 1 200 0 0 0 0 0 0 b 0 0 1 0 0 0 1 a 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 300 0 1000 0 7 7 0 0 0 0 1 0 0 0 1 b 202 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1000 0 1100 0 7 8 0 0 0 0 1 0 1 1000 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1004 0 1010 0 1 2 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1010 0 1110 0 3 3 0 0 1 0 1 0 1 1010 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1014 0 1020 0 ffffffff 1 0 0 4 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1020 0 1120 0 1 ffffffff 0 0 4 0 1 0 1 1020 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1024 0 1030 0 1 ffffffff 0 0 5 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1030 0 1130 0 ffffffff 1 0 0 5 0 1 0 1 1030 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1034 0 1040 0 1 ffffffff 0 0 6 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1040 0 1140 0 ffffffff 1 0 0 6 0 1 0 1 1040 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1044 0 1050 0 ffffffff 1 0 0 7 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 1 0 0 1050 0 1150 0 1 ffffffff 0 0 7 0 1 0 1 1050 0 0 0 0 0 0 0 0 0 0
1 1 2 0 1 0 0 0 500 0 2000 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 1 0 504 0 1 1 0 0 0 c 0 0 1 0 1 2000 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 2 0 508 0 2200 0 0 0 0 c 2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 0 0 1 0 2000 0 2 2 0 0 0 d 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1
1 0 2 0 0 0 2 0 3000 0 3000 8 0 0 0 e 2 0 1 0 0 0 1 d 4 0 0 0 0 0 0 0
1 0 2 0 0 0 3 0 3004 0 3100 4 0 0 cafe 0 2 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 3 0 3004 0 3100 4 0 0 cafe 0 2 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0
1 0 2 0 0 0 3 0 3004 0 3100 4 0 0 cafe 0 2 0 0 0 0 0 0 0 0 1 0 2 e 0 3008 0
1 0 2 1 0 0 0 0 4000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0 cafe 3104 0
1 1 2 0 0 0 1 0 4004 0 9 1 0 0 0 f 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 0 0 0 1 0 4004 0 9 1 0 0 0 f 0 0 1 0 1 4004 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 f a 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: sim/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int NUM_COLS = 32;

    logic                    clk;
    logic                    resetb;
    ex_pkg::ids_op_t         ids_op;
    logic                    lsq_full;
    logic                    lsq_empty;
    logic                    ids_stall;
    logic                    regd_cncl_load;
    logic                    pfu_jump;
    logic [ex_pkg::XLEN-1:0] pfu_jump_addr;
    ex_pkg::wb_t             wb;
    ex_pkg::lsq_req_t        lsq_req;

    string lines[$];
    int    n_lines = 0;

    ex_clk_gen u_clk_gen (
        .clk_o    (clk),
        .resetb_o (resetb)
    );

    ex_stage dut (
        .clk_i                (clk),
        .resetb_i             (resetb),
        .ids_op_i             (ids_op),
        .ids_stall_o          (ids_stall),
        .ids_regd_cncl_load_o (regd_cncl_load),
        .lsq_full_i           (lsq_full),
        .lsq_empty_i          (lsq_empty),
        .pfu_jump_o           (pfu_jump),
        .pfu_jump_addr_o      (pfu_jump_addr),
        .wb_o                 (wb),
        .lsq_req_o            (lsq_req)
    );

    // ------------------------------
    // reporting and compares
    // ------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(input ex_pkg::wb_t got, input ex_pkg::wb_t exp);
        // addr and data only matter when the strobe fires
        if (got.wr !== exp.wr || (exp.wr && got !== exp)) begin
            stop_with_error($sformatf("mismatch wb_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_lsq(input ex_pkg::lsq_req_t got, input ex_pkg::lsq_req_t exp);
        if (got.lq_wr !== exp.lq_wr || got.sq_wr !== exp.sq_wr
            || ((exp.lq_wr || exp.sq_wr) && got !== exp)) begin
            stop_with_error($sformatf("mismatch lsq_req_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_jump(input logic got, input logic [ex_pkg::XLEN-1:0] got_addr,
                              input logic exp, input logic [ex_pkg::XLEN-1:0] exp_addr);
        if (got !== exp || (exp && got_addr !== exp_addr)) begin
            stop_with_error($sformatf("mismatch pfu_jump_o/addr got %h/%h expected %h/%h",
                                      got, got_addr, exp, exp_addr));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f[NUM_COLS];

        ids_op    = '0;
        lsq_full  = 1'b0;
        lsq_empty = 1'b1;

        fd = $fopen("sim/ex_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open the pattern file sim/ex_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            stop_with_error("the pattern file holds no pattern lines");
        end
        n_lines = lines.size();

        // controls stay low while reset is held
        @(posedge clk);
        #20;
        check_bit("ids_stall_o", ids_stall, 1'b0);
        check_bit("pfu_jump_o", pfu_jump, 1'b0);
        check_bit("wb_o.wr", wb.wr, 1'b0);
        check_bit("lsq_req_o.lq_wr", lsq_req.lq_wr, 1'b0);
        check_bit("lsq_req_o.sq_wr", lsq_req.sq_wr, 1'b0);
        check_bit("ids_regd_cncl_load_o", regd_cncl_load, 1'b0);
        wait (resetb === 1'b1);

        foreach (lines[n]) begin
            ex_pkg::wb_t      exp_wb;
            ex_pkg::lsq_req_t exp_lsq;

            cnt = $sscanf(lines[n],
                          "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                          f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                          f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
                          f[24], f[25], f[26], f[27], f[28], f[29], f[30], f[31]);
            if (cnt != NUM_COLS) begin
                stop_with_error($sformatf("pattern line %0d has %0d columns", n + 1, cnt));
            end

            @(posedge clk);
            #10;
            ids_op.valid         = f[0][0];
            ids_op.sofid         = ex_pkg::sofid_t'(f[1][0]);
            ids_op.ins_size      = f[2][1:0];
            ids_op.fencei        = f[3][0];
            ids_op.jump          = f[4][0];
            ids_op.cond          = f[5][0];
            ids_op.zone          = ex_pkg::zone_t'(f[6][1:0]);
            ids_op.link          = f[7][0];
            ids_op.pc            = f[8];
            ids_op.alu_op        = ex_pkg::alu_op_t'(f[9][3:0]);
            ids_op.operand_left  = f[10];
            ids_op.operand_right = f[11];
            ids_op.regs1_data    = f[12];
            ids_op.cmp_right     = f[13];
            ids_op.regs2_data    = f[14];
            ids_op.regd_addr     = f[15][ex_pkg::REG_ADDR_W-1:0];
            ids_op.funct3        = f[16][2:0];
            lsq_full             = f[17][0];
            lsq_empty            = f[18][0];

            exp_wb.wr            = f[22][0];
            exp_wb.addr          = f[23][ex_pkg::REG_ADDR_W-1:0];
            exp_wb.data          = f[24];
            exp_lsq.lq_wr        = f[25][0];
            exp_lsq.sq_wr        = f[26][0];
            exp_lsq.funct3       = f[27][2:0];
            exp_lsq.regd_addr    = f[28][ex_pkg::REG_ADDR_W-1:0];
            exp_lsq.regs2_data   = f[29];
            exp_lsq.addr         = f[30];

            // sample just before the next edge
            #89;
            check_bit("ids_stall_o", ids_stall, f[19][0]);
            check_jump(pfu_jump, pfu_jump_addr, f[20][0], f[21]);
            check_wb(wb, exp_wb);
            check_lsq(lsq_req, exp_lsq);
            check_bit("ids_regd_cncl_load_o", regd_cncl_load, f[31][0]);
        end

        $display("** PASS **");
        $finish;
    end

    // watchdog sized from the pattern count
    initial begin
        wait (n_lines > 0);
        #((n_lines + 10) * 100);
        $display("timeout: the pattern run did not finish in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic             clk_i,
    input  logic             resetb_i,
    input  logic             stage_en_i,
    input  ex_pkg::ids_op_t  ids_op_i,
    output ex_pkg::alu_res_t res_o
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic                       slt;
    logic                       sltu;
    logic [ex_pkg::XLEN-1:0]    result;
    logic                       cmp_eq;
    logic                       cmp_lt;
    logic                       cmp_ltu;
    logic                       cmp;
    ex_pkg::alu_res_t           res_q;

    // ----------------------------
    // arithmetic
    // ----------------------------
    assign shamt = ids_op_i.operand_right[ex_pkg::SHAMT_W-1:0];
    assign slt   = $signed(ids_op_i.operand_left) < $signed(ids_op_i.operand_right);
    assign sltu  = ids_op_i.operand_left < ids_op_i.operand_right;

    always_comb begin
        case (ids_op_i.alu_op)
            ex_pkg::ADD:  result = ids_op_i.operand_left + ids_op_i.operand_right;
            ex_pkg::SUB:  result = ids_op_i.operand_left - ids_op_i.operand_right;
            ex_pkg::AND:  result = ids_op_i.operand_left & ids_op_i.operand_right;
            ex_pkg::OR:   result = ids_op_i.operand_left | ids_op_i.operand_right;
            ex_pkg::XOR:  result = ids_op_i.operand_left ^ ids_op_i.operand_right;
            ex_pkg::SLL:  result = ids_op_i.operand_left << shamt;
            ex_pkg::SRL:  result = ids_op_i.operand_left >> shamt;
            ex_pkg::SRA:  result = $signed(ids_op_i.operand_left) >>> shamt;
            ex_pkg::SLT:  result = {{(ex_pkg::XLEN-1){1'b0}}, slt};
            ex_pkg::SLTU: result = {{(ex_pkg::XLEN-1){1'b0}}, sltu};
            default:      result = '0;
        endcase
    end

    // ----------------------------
    // branch compare
    // ----------------------------
    // rs1 against rs2 or immediate, picked by the decoder
    assign cmp_eq  = ids_op_i.regs1_data == ids_op_i.cmp_right;
    assign cmp_lt  = $signed(ids_op_i.regs1_data) < $signed(ids_op_i.cmp_right);
    assign cmp_ltu = ids_op_i.regs1_data < ids_op_i.cmp_right;

    always_comb begin
        case (ex_pkg::cmp_op_t'(ids_op_i.funct3))
            ex_pkg::EQ:  cmp = cmp_eq;
            ex_pkg::NE:  cmp = ~cmp_eq;
            ex_pkg::LT:  cmp = cmp_lt;
            ex_pkg::GE:  cmp = ~cmp_lt;
            ex_pkg::LTU: cmp = cmp_ltu;
            ex_pkg::GEU: cmp = ~cmp_ltu;
            default:     cmp = 1'b0;
        endcase
    end

    // ----------------------------
    // output register
    // ----------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            res_q.result <= result;
            res_q.cmp    <= cmp;
        end
    end

    assign res_o = res_q;

    // an operation outside the table would silently write zero
    a_alu_op_known: assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        stage_en_i && ids_op_i.valid |-> ids_op_i.alu_op inside {
            ex_pkg::ADD, ex_pkg::SUB, ex_pkg::AND, ex_pkg::OR, ex_pkg::XOR,
            ex_pkg::SLL, ex_pkg::SRL, ex_pkg::SRA, ex_pkg::SLT, ex_pkg::SLTU}
    );

endmodule

// File: verilog/ex_commit.sv
`timescale 1ns/1ps

module ex_commit (
    input  logic                    clk_i,
    input  logic                    resetb_i,
    input  ex_pkg::ex_ctrl_t        ctrl_i,
    input  ex_pkg::alu_res_t        res_i,
    input  logic                    lsq_full_i,
    input  logic                    lsq_empty_i,
    output logic                    stage_en_o,
    output logic                    ids_stall_o,
    output logic                    pfu_jump_o,
    output logic [ex_pkg::XLEN-1:0] pfu_jump_addr_o,
    output ex_pkg::wb_t             wb_o,
    output ex_pkg::lsq_req_t        lsq_req_o,
    output logic                    ids_regd_cncl_load_o
);

    ex_pkg::sofid_t flush_q;
    logic           live;
    logic           commit;
    logic           stall;
    logic           stage_en;

    // ----------------------------
    // qualification
    // ----------------------------
    // while flushing, only the redirect target gets through
    assign live   = ctrl_i.valid
                  & ((flush_q == ex_pkg::SOFID_RUN) | (ctrl_i.sofid == ex_pkg::SOFID_JUMP));
    assign commit = live & (~ctrl_i.cond | res_i.cmp);

    // flush tracking
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            flush_q <= ex_pkg::SOFID_RUN;
        end else if (pfu_jump_o) begin
            flush_q <= ex_pkg::SOFID_JUMP;
        end else if (stage_en && ctrl_i.valid && ctrl_i.sofid == ex_pkg::SOFID_JUMP) begin
            flush_q <= ex_pkg::SOFID_RUN;
        end
    end

    // ----------------------------
    // stall
    // ----------------------------
    // queue full for a memory op, or fence.i waiting for the queue to drain
    assign stall = commit
                 & ((lsq_full_i & (ctrl_i.lq_wr | ctrl_i.sq_wr))
                 | (~lsq_empty_i & ctrl_i.fencei));

    assign stage_en    = ~stall;
    assign stage_en_o  = stage_en;
    assign ids_stall_o = stall;

    // ----------------------------
    // jump
    // ----------------------------
    assign pfu_jump_o = stage_en & commit & (ctrl_i.jump | ctrl_i.fencei);

    // fence.i refetches the next instruction
    always_comb begin
        if (ctrl_i.fencei) begin
            pfu_jump_addr_o = ctrl_i.pc_inc;
        end else begin
            pfu_jump_addr_o = res_i.result;
        end
    end

    // ----------------------------
    // write-back and queue
    // ----------------------------
    always_comb begin
        wb_o.wr   = stage_en & commit & ctrl_i.regd_wr;
        wb_o.addr = ctrl_i.regd_addr;
        // link writes the return address
        if (ctrl_i.link) begin
            wb_o.data = ctrl_i.pc_inc;
        end else begin
            wb_o.data = res_i.result;
        end
    end

    always_comb begin
        lsq_req_o.lq_wr      = stage_en & commit & ctrl_i.lq_wr;
        lsq_req_o.sq_wr      = stage_en & commit & ctrl_i.sq_wr;
        lsq_req_o.funct3     = ctrl_i.funct3;
        lsq_req_o.regd_addr  = ctrl_i.regd_addr;
        lsq_req_o.regs2_data = ctrl_i.regs2_data;
        lsq_req_o.addr       = res_i.result;
    end

    // decoder releases the scoreboard entry of a killed load
    assign ids_regd_cncl_load_o = stage_en & ~commit & ctrl_i.valid & ctrl_i.lq_wr;

    // ----------------------------
    // checks
    // ----------------------------
    a_no_jump_in_stall: assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        !(pfu_jump_o && ids_stall_o)
    );

    a_no_strobe_in_stall: assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        ids_stall_o |-> !(wb_o.wr || lsq_req_o.lq_wr || lsq_req_o.sq_wr
                          || ids_regd_cncl_load_o)
    );

endmodule

// File: verilog/ex_issue_reg.sv
`timescale 1ns/1ps

module ex_issue_reg (
    input  logic             clk_i,
    input  logic             resetb_i,
    input  logic             stage_en_i,
    input  ex_pkg::ids_op_t  ids_op_i,
    output ex_pkg::ex_ctrl_t ctrl_o
);

    ex_pkg::ex_ctrl_t ctrl_d;
    ex_pkg::ex_ctrl_t payload_q;
    logic             valid_q;

    // ----------------------------
    // next state
    // ----------------------------
    always_comb begin
        ctrl_d            = '0;
        ctrl_d.valid      = ids_op_i.valid;
        ctrl_d.sofid      = ids_op_i.sofid;
        ctrl_d.fencei     = ids_op_i.fencei;
        ctrl_d.jump       = ids_op_i.jump;
        ctrl_d.cond       = ids_op_i.cond;
        ctrl_d.link       = ids_op_i.link;
        ctrl_d.regs2_data = ids_op_i.regs2_data;
        ctrl_d.regd_addr  = ids_op_i.regd_addr;
        ctrl_d.funct3     = ids_op_i.funct3;
        // size is in halfwords
        ctrl_d.pc_inc     = ids_op_i.pc
                          + {{(ex_pkg::XLEN-3){1'b0}}, ids_op_i.ins_size, 1'b0};
        // zone to one-hot write enables
        case (ids_op_i.zone)
            ex_pkg::ZONE_REGFILE: ctrl_d.regd_wr = 1'b1;
            ex_pkg::ZONE_LOADQ:   ctrl_d.lq_wr   = 1'b1;
            ex_pkg::ZONE_STOREQ:  ctrl_d.sq_wr   = 1'b1;
            default: begin
            end
        endcase
    end

    // ----------------------------
    // registers
    // ----------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q <= 1'b0;
        end else if (stage_en_i) begin
            valid_q <= ctrl_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            payload_q <= ctrl_d;
        end
    end

    always_comb begin
        ctrl_o       = payload_q;
        ctrl_o.valid = valid_q;
    end

    // at most one destination per instruction
    a_zone_onehot: assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        ctrl_o.valid |-> $onehot0({ctrl_o.lq_wr, ctrl_o.sq_wr, ctrl_o.regd_wr})
    );

endmodule

// File: verilog/ex_pkg.sv
package ex_pkg;

    // ----------------------------
    // widths
    // ----------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // shift amount taken from the low bits of the right operand
    localparam int SHAMT_W    = 5;

    // ----------------------------
    // encodings
    // ----------------------------
    // first instruction after a redirect carries SOFID_JUMP
    typedef enum logic [0:0] {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_t;

    // where the result of an instruction goes
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_t;

    // branch compare, funct3 coding of the B-type instructions
    typedef enum logic [2:0] {
        EQ  = 3'b000,
        NE  = 3'b001,
        LT  = 3'b100,
        GE  = 3'b101,
        LTU = 3'b110,
        GEU = 3'b111
    } cmp_op_t;

    // ----------------------------
    // bundles
    // ----------------------------
    // decoded instruction handed over by the decoder
    typedef struct packed {
        logic                  valid;
        sofid_t                sofid;
        logic [1:0]            ins_size;
        logic                  fencei;
        logic                  jump;
        logic                  cond;
        zone_t                 zone;
        logic                  link;
        logic [XLEN-1:0]       pc;
        alu_op_t               alu_op;
        logic [XLEN-1:0]       operand_left;
        logic [XLEN-1:0]       operand_right;
        logic [XLEN-1:0]       regs1_data;
        logic [XLEN-1:0]       cmp_right;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ids_op_t;

    // control of the instruction sitting in execute
    typedef struct packed {
        logic                  valid;
        sofid_t                sofid;
        logic                  fencei;
        logic                  jump;
        logic                  cond;
        logic                  lq_wr;
        logic                  sq_wr;
        logic                  regd_wr;
        logic                  link;
        logic [XLEN-1:0]       pc_inc;
        logic [XLEN-1:0]       regs2_data;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [2:0]            funct3;
    } ex_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            cmp;
    } alu_res_t;

    // register file write-back
    typedef struct packed {
        logic                  wr;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

    // load/store queue request
    typedef struct packed {
        logic                  lq_wr;
        logic                  sq_wr;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic [XLEN-1:0]       regs2_data;
        logic [XLEN-1:0]       addr;
    } lsq_req_t;

endpackage

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                    clk_i,
    input  logic                    resetb_i,
    // decoder side
    input  ex_pkg::ids_op_t         ids_op_i,
    output logic                    ids_stall_o,
    output logic                    ids_regd_cncl_load_o,
    // load/store queue status
    input  logic                    lsq_full_i,
    input  logic                    lsq_empty_i,
    // prefetch unit redirect
    output logic                    pfu_jump_o,
    output logic [ex_pkg::XLEN-1:0] pfu_jump_addr_o,
    // results
    output ex_pkg::wb_t             wb_o,
    output ex_pkg::lsq_req_t        lsq_req_o
);

    // issue stage enable, low while commit stalls
    logic               stage_en;
    ex_pkg::ex_ctrl_t   ctrl;
    ex_pkg::alu_res_t   res;

    // ----------------------------
    // issue stage
    // ----------------------------
    // both halves capture on the same edge so ctrl and res stay paired
    ex_issue_reg u_issue_reg (
        .clk_i      (clk_i),
        .resetb_i   (resetb_i),
        .stage_en_i (stage_en),
        .ids_op_i   (ids_op_i),
        .ctrl_o     (ctrl)
    );

    ex_alu u_alu (
        .clk_i      (clk_i),
        .resetb_i   (resetb_i),
        .stage_en_i (stage_en),
        .ids_op_i   (ids_op_i),
        .res_o      (res)
    );

    // ----------------------------
    // commit stage
    // ----------------------------
    ex_commit u_commit (
        .clk_i                (clk_i),
        .resetb_i             (resetb_i),
        .ctrl_i               (ctrl),
        .res_i                (res),
        .lsq_full_i           (lsq_full_i),
        .lsq_empty_i          (lsq_empty_i),
        .stage_en_o           (stage_en),
        .ids_stall_o          (ids_stall_o),
        .pfu_jump_o           (pfu_jump_o),
        .pfu_jump_addr_o      (pfu_jump_addr_o),
        .wb_o                 (wb_o),
        .lsq_req_o            (lsq_req_o),
        .ids_regd_cncl_load_o (ids_regd_cncl_load_o)
    );

endmodule
